/* logic/dct_fixed_pkg.sv */
//--------------------------------------------------------------------
// fixed point types and constants for the 8-point Loeffler DCT
// samples and results are signed 7Q8 and rotation constants are 1Q8.
// a raw product is scaled back to 7Q8 by taking its middle slice
//--------------------------------------------------------------------
package dct_fixed_pkg;

    localparam int SAMPLE_W = 16;
    localparam int FRAC_W   = 8;               // fraction bits of samples and constants
    localparam int COEFF_W  = 9;
    localparam int PROD_W   = 32;
    localparam int POINTS   = 8;
    localparam int IDX_W    = $clog2(POINTS);  // sample / result index

    typedef logic signed [SAMPLE_W-1:0] sample_t;   // 7Q8
    typedef logic        [COEFF_W-1:0]  coeff_t;    // unsigned 1Q8
    typedef logic signed [PROD_W-1:0]   product_t;  // raw product before rescaling

    // odd part rotation by 3pi/16
    localparam coeff_t C3_COS = 9'd213;
    localparam coeff_t C3_SIN = 9'd142;

    // odd part rotation by pi/16
    localparam coeff_t C1_COS = 9'd251;
    localparam coeff_t C1_SIN = 9'd50;

    // even part rotation, scaled by sqrt2
    localparam coeff_t R2C6_COS = 9'd139;
    localparam coeff_t R2C6_SIN = 9'd334;

    localparam coeff_t SQRT2   = 9'd362;
    localparam coeff_t SQRT2_Q = 9'd91;    // sqrt2 / 4 for the dc and nyquist terms

endpackage

/* logic/dct_ucode_pkg.sv */
//--------------------------------------------------------------------
// microcode definitions for the DCT sequencer
// one control word per step drives the operand path, the multiplier
// coefficient and the write port
//--------------------------------------------------------------------
package dct_ucode_pkg;

    localparam int SPAD_DEPTH = 32;
    localparam int SPAD_AW    = $clog2(SPAD_DEPTH);
    localparam int PC_W       = 6;
    localparam int UCODE_LEN  = 51;    // steps 0 to 50, the last one settles

    typedef enum logic {SRC_FETCH, SRC_SPAD} read_src_e;
    typedef enum logic {OP_MEM, OP_MUL} op_src_e;
    typedef enum logic {DEST_SPAD, DEST_OUT} write_dest_e;
    typedef enum logic {WSRC_ADDER, WSRC_MUL} write_src_e;

    typedef enum logic [2:0] {
        COEF_C3_COS,
        COEF_C3_SIN,
        COEF_C1_COS,
        COEF_C1_SIN,
        COEF_R2C6_COS,
        COEF_R2C6_SIN,
        COEF_SQRT2,
        COEF_SQRT2_Q
    } coeff_sel_e;

    typedef struct packed {
        logic [SPAD_AW-1:0] read_addr;   // input buffer or scratchpad
        read_src_e          read_src;
        logic               latch_op1;
        op_src_e            op1_src;
        logic               negate_op1;
        op_src_e            op2_src;
        logic               negate_op2;
        coeff_sel_e         coeff_sel;   // pairs with the word on the operand bus
        logic [SPAD_AW-1:0] write_addr;  // low bits give the result index
        write_dest_e        write_dest;
        logic               write_en;
        write_src_e         write_src;
    } ucode_t;

endpackage

/* logic/dct_scratchpad.sv */
`timescale 1ns/1ns
//--------------------------------------------------------------------
// scratchpad for DCT intermediates
// 32 words with one write port and a registered read port, the data
// for a read address appears one clock later
//--------------------------------------------------------------------
module dct_scratchpad (
    input  logic                   clock,
    input  logic [4:0]             read_addr,
    output dct_fixed_pkg::sample_t read_data,
    input  logic                   write_en,
    input  logic [4:0]             write_addr,
    input  dct_fixed_pkg::sample_t write_data
);
    import dct_fixed_pkg::*;

    sample_t mem [0:31];

    // a read of the address being written returns the old word
    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];
    end

    // the program keeps three rows of eight words, 0 to 23
    write_in_range: assert property (@(posedge clock)
        write_en |-> (write_addr < 5'(3 * POINTS)));

endmodule

/* logic/dct_multiplier.sv */
`timescale 1ns/1ns
//--------------------------------------------------------------------
// two stage constant multiplier of the DCT engine
// operand and coefficient are registered, then the signed product,
// and the 7Q8 slice of it comes out two clocks after the inputs
//--------------------------------------------------------------------
module dct_multiplier (
    input  logic                      clock,
    input  logic                      nreset,
    input  dct_fixed_pkg::sample_t    operand,
    input  dct_ucode_pkg::coeff_sel_e coeff_sel,
    output dct_fixed_pkg::sample_t    product
);
    import dct_fixed_pkg::*;
    import dct_ucode_pkg::*;

    coeff_t   coeff;
    sample_t  op_q;
    coeff_t   coeff_q;
    product_t prod_q;

    always_comb begin
        unique case (coeff_sel)
            COEF_C3_COS:   coeff = C3_COS;
            COEF_C3_SIN:   coeff = C3_SIN;
            COEF_C1_COS:   coeff = C1_COS;
            COEF_C1_SIN:   coeff = C1_SIN;
            COEF_R2C6_COS: coeff = R2C6_COS;
            COEF_R2C6_SIN: coeff = R2C6_SIN;
            COEF_SQRT2:    coeff = SQRT2;
            COEF_SQRT2_Q:  coeff = SQRT2_Q;
        endcase
    end

    // new pair every clock, two in flight
    always_ff @(posedge clock) begin
        if (nreset) begin
            op_q    <= '0;
            coeff_q <= '0;
            prod_q  <= '0;
        end else begin
            op_q    <= operand;
            coeff_q <= coeff;
            prod_q  <= product_t'(op_q) * product_t'(coeff_q);  // coefficient zero extended
        end
    end

    assign product = prod_q[SAMPLE_W+FRAC_W-1:FRAC_W];  // back to 7Q8

endmodule

/* logic/dct_sequencer.sv */
`timescale 1ns/1ns
//--------------------------------------------------------------------
// microcode sequencer of the DCT engine
// a saturating program counter steps the table once per clock and
// finished stays high from the last step until the next reset
//--------------------------------------------------------------------
module dct_sequencer (
    input  logic                  clock,
    input  logic                  nreset,
    output dct_ucode_pkg::ucode_t ctrl,
    output logic                  finished
);
    import dct_fixed_pkg::*;
    import dct_ucode_pkg::*;

    logic [PC_W-1:0] pc;

    // plain read, nothing else happens
    function automatic ucode_t rd(read_src_e src, logic [SPAD_AW-1:0] addr);
        ucode_t w;
        w = '0;
        w.read_src  = src;
        w.read_addr = addr;
        return w;
    endfunction

    // read plus the coefficient for the word now on the bus
    function automatic ucode_t rdm(read_src_e src, logic [SPAD_AW-1:0] addr, coeff_sel_e c);
        ucode_t w;
        w = rd(src, addr);
        w.coeff_sel = c;
        return w;
    endfunction

    function automatic ucode_t lat(ucode_t w, op_src_e src);
        w.latch_op1 = 1'b1;
        w.op1_src   = src;
        return w;
    endfunction

    function automatic ucode_t wr(ucode_t w, write_dest_e dest, logic [SPAD_AW-1:0] addr,
                                  op_src_e op2, logic neg1, logic neg2);
        w.write_en   = 1'b1;
        w.write_src  = WSRC_ADDER;
        w.write_dest = dest;
        w.write_addr = addr;
        w.op2_src    = op2;
        w.negate_op1 = neg1;
        w.negate_op2 = neg2;
        return w;
    endfunction

    function automatic ucode_t wsp(ucode_t w, logic [SPAD_AW-1:0] addr, op_src_e op2,
                                   logic neg1, logic neg2);
        return wr(w, DEST_SPAD, addr, op2, neg1, neg2);
    endfunction

    function automatic ucode_t wout(ucode_t w, logic [IDX_W-1:0] idx, op_src_e op2,
                                    logic neg1, logic neg2);
        return wr(w, DEST_OUT, SPAD_AW'(idx), op2, neg1, neg2);
    endfunction

    // product goes to the result port untouched
    function automatic ucode_t wmul(ucode_t w, logic [IDX_W-1:0] idx);
        w.write_en   = 1'b1;
        w.write_src  = WSRC_MUL;
        w.write_dest = DEST_OUT;
        w.write_addr = SPAD_AW'(idx);
        return w;
    endfunction

    always_ff @(posedge clock) begin
        if (nreset) begin
            pc <= '0;
        end else if (pc != PC_W'(UCODE_LEN)) begin
            pc <= pc + 1'b1;
        end
    end

    assign finished = (pc == PC_W'(UCODE_LEN - 1)) || (pc == PC_W'(UCODE_LEN));

    // data read in step n is on the bus in step n+1, products land two steps after that
    always_comb begin
        case (pc)
            // stage 1, the second input of each pair is read twice
            0:  ctrl = rd(SRC_FETCH, 5'd0);
            1:  ctrl = lat(rd(SRC_FETCH, 5'd7), OP_MEM);
            2:  ctrl = wsp(rd(SRC_FETCH, 5'd7), 5'd0, OP_MEM, 1'b0, 1'b0);   // s0
            3:  ctrl = wsp(rd(SRC_FETCH, 5'd1), 5'd7, OP_MEM, 1'b0, 1'b1);   // s7
            4:  ctrl = lat(rd(SRC_FETCH, 5'd6), OP_MEM);
            5:  ctrl = wsp(rd(SRC_FETCH, 5'd6), 5'd1, OP_MEM, 1'b0, 1'b0);
            6:  ctrl = wsp(rd(SRC_FETCH, 5'd2), 5'd6, OP_MEM, 1'b0, 1'b1);
            7:  ctrl = lat(rd(SRC_FETCH, 5'd5), OP_MEM);
            8:  ctrl = wsp(rd(SRC_FETCH, 5'd5), 5'd2, OP_MEM, 1'b0, 1'b0);
            9:  ctrl = wsp(rd(SRC_FETCH, 5'd3), 5'd5, OP_MEM, 1'b0, 1'b1);
            10: ctrl = lat(rd(SRC_FETCH, 5'd4), OP_MEM);
            11: ctrl = wsp(rd(SRC_FETCH, 5'd4), 5'd3, OP_MEM, 1'b0, 1'b0);
            12: ctrl = wsp(rd(SRC_SPAD, 5'd0), 5'd4, OP_MEM, 1'b0, 1'b1);
            // even butterflies into 8..11
            13: ctrl = lat(rd(SRC_SPAD, 5'd3), OP_MEM);
            14: ctrl = wsp(rd(SRC_SPAD, 5'd3), 5'd8, OP_MEM, 1'b0, 1'b0);   // e0
            15: ctrl = wsp(rd(SRC_SPAD, 5'd1), 5'd11, OP_MEM, 1'b0, 1'b1);  // e3
            16: ctrl = lat(rd(SRC_SPAD, 5'd2), OP_MEM);
            17: ctrl = wsp(rd(SRC_SPAD, 5'd2), 5'd9, OP_MEM, 1'b0, 1'b0);   // e1
            18: ctrl = wsp(rd(SRC_SPAD, 5'd4), 5'd10, OP_MEM, 1'b0, 1'b1);  // e2
            // multiplier stream, rotations a d b c into 12 15 13 14
            19: ctrl = rdm(SRC_SPAD, 5'd7, COEF_C3_COS);
            20: ctrl = rdm(SRC_SPAD, 5'd4, COEF_C3_SIN);
            21: ctrl = lat(rdm(SRC_SPAD, 5'd7, COEF_C3_SIN), OP_MUL);
            22: ctrl = wsp(rdm(SRC_SPAD, 5'd5, COEF_C3_COS), 5'd12, OP_MUL, 1'b0, 1'b0);
            23: ctrl = lat(rdm(SRC_SPAD, 5'd6, COEF_C1_COS), OP_MUL);
            24: ctrl = wsp(rdm(SRC_SPAD, 5'd5, COEF_C1_SIN), 5'd15, OP_MUL, 1'b1, 1'b0);
            25: ctrl = lat(rdm(SRC_SPAD, 5'd6, COEF_C1_SIN), OP_MUL);
            26: ctrl = wsp(rdm(SRC_SPAD, 5'd8, COEF_C1_COS), 5'd13, OP_MUL, 1'b0, 1'b0);
            // even outputs 0 4 2 6 straight from product pairs
            27: ctrl = lat(rdm(SRC_SPAD, 5'd9, COEF_SQRT2_Q), OP_MUL);
            28: ctrl = wsp(rdm(SRC_SPAD, 5'd8, COEF_SQRT2_Q), 5'd14, OP_MUL, 1'b1, 1'b0);
            29: ctrl = lat(rdm(SRC_SPAD, 5'd9, COEF_SQRT2_Q), OP_MUL);
            30: ctrl = wout(rdm(SRC_SPAD, 5'd10, COEF_SQRT2_Q), 3'd0, OP_MUL, 1'b0, 1'b0);
            31: ctrl = lat(rdm(SRC_SPAD, 5'd11, COEF_R2C6_COS), OP_MUL);
            32: ctrl = wout(rdm(SRC_SPAD, 5'd10, COEF_R2C6_SIN), 3'd4, OP_MUL, 1'b0, 1'b1);
            33: ctrl = lat(rdm(SRC_SPAD, 5'd11, COEF_R2C6_SIN), OP_MUL);
            34: ctrl = wout(rdm(SRC_FETCH, 5'd0, COEF_R2C6_COS), 3'd2, OP_MUL, 1'b0, 1'b0);
            35: ctrl = lat(rd(SRC_FETCH, 5'd0), OP_MUL);
            36: ctrl = wout(rd(SRC_SPAD, 5'd12), 3'd6, OP_MUL, 1'b1, 1'b0);
            // odd butterflies f0 f2 f3 f1 into 20..23
            37: ctrl = lat(rd(SRC_SPAD, 5'd14), OP_MEM);
            38: ctrl = wsp(rd(SRC_SPAD, 5'd14), 5'd20, OP_MEM, 1'b0, 1'b0);
            39: ctrl = wsp(rd(SRC_SPAD, 5'd13), 5'd22, OP_MEM, 1'b0, 1'b1);
            40: ctrl = lat(rd(SRC_SPAD, 5'd15), OP_MEM);
            41: ctrl = wsp(rd(SRC_SPAD, 5'd15), 5'd23, OP_MEM, 1'b0, 1'b0);
            42: ctrl = wsp(rd(SRC_SPAD, 5'd20), 5'd21, OP_MEM, 1'b1, 1'b0);
            43: ctrl = lat(rd(SRC_SPAD, 5'd23), OP_MEM);
            44: ctrl = wout(rd(SRC_SPAD, 5'd23), 3'd1, OP_MEM, 1'b0, 1'b0);
            45: ctrl = wout(rd(SRC_SPAD, 5'd21), 3'd7, OP_MEM, 1'b1, 1'b0);
            46: ctrl = rdm(SRC_SPAD, 5'd22, COEF_SQRT2);   // f1 on the bus
            47: ctrl = rdm(SRC_FETCH, 5'd0, COEF_SQRT2);   // f2 on the bus
            48: ctrl = wmul(rd(SRC_FETCH, 5'd0), 3'd3);
            49: ctrl = wmul(rd(SRC_FETCH, 5'd0), 3'd5);
            default: ctrl = '0;                           // step 50 and beyond stay idle
        endcase
    end

    pc_in_range: assert property (@(posedge clock) disable iff (nreset)
        pc <= PC_W'(UCODE_LEN));

    // once the program ends only a reset brings finished down
    finished_held: assert property (@(posedge clock) disable iff (nreset)
        $fell(finished) |-> $past(nreset));

endmodule

/* logic/dct_datapath.sv */
`timescale 1ns/1ns
//--------------------------------------------------------------------
// operand path of the DCT engine
// picks the operand bus, holds the operand latch and forms
// +-latch +-operand2, then routes the result to the scratchpad or
// out as a result strobe
//--------------------------------------------------------------------
module dct_datapath (
    input  logic                            clock,
    input  logic                            nreset,
    input  dct_ucode_pkg::ucode_t           ctrl,
    input  dct_fixed_pkg::sample_t          src_data,
    input  dct_fixed_pkg::sample_t          spad_data,
    input  dct_fixed_pkg::sample_t          mul_product,
    output dct_fixed_pkg::sample_t          operand_bus,
    output logic                            spad_wren,
    output dct_fixed_pkg::sample_t          spad_wdata,
    output logic                            result_wren,
    output logic [dct_fixed_pkg::IDX_W-1:0] result_addr,
    output dct_fixed_pkg::sample_t          result_data
);
    import dct_fixed_pkg::*;
    import dct_ucode_pkg::*;

    read_src_e bus_src;   // source of the read issued last step
    sample_t   op_latch;
    sample_t   op2;
    sample_t   lhs;
    sample_t   rhs;
    sample_t   wdata;

    always_ff @(posedge clock) begin
        if (nreset) begin
            bus_src  <= SRC_FETCH;
            op_latch <= '0;
        end else begin
            bus_src <= ctrl.read_src;
            if (ctrl.latch_op1) begin
                op_latch <= (ctrl.op1_src == OP_MUL) ? mul_product : operand_bus;
            end
        end
    end

    // both memories answer one clock after the address
    assign operand_bus = (bus_src == SRC_SPAD) ? spad_data : src_data;

    assign op2 = (ctrl.op2_src == OP_MUL) ? mul_product : operand_bus;

    // sums wrap to 16 bits
    assign lhs   = ctrl.negate_op1 ? sample_t'(-op_latch) : op_latch;
    assign rhs   = ctrl.negate_op2 ? sample_t'(-op2) : op2;
    assign wdata = (ctrl.write_src == WSRC_MUL) ? mul_product : sample_t'(lhs + rhs);

    assign spad_wren   = ctrl.write_en && (ctrl.write_dest == DEST_SPAD);
    assign spad_wdata  = wdata;
    assign result_wren = ctrl.write_en && (ctrl.write_dest == DEST_OUT);
    assign result_addr = ctrl.write_addr[IDX_W-1:0];
    assign result_data = wdata;   // only meaningful with result_wren

    // every enabled write carries a defined value
    write_data_known: assert property (@(posedge clock) disable iff (nreset)
        ctrl.write_en |-> !$isunknown(wdata));

endmodule

/* logic/loeffler_dct8.sv */
`timescale 1ns/1ns
//--------------------------------------------------------------------
// 8-point Loeffler DCT engine, top level
// reads eight 7Q8 samples from an external buffer with one clock of
// latency and strobes out eight results with their index. finished
// rises at the end of the program and a new transform needs a reset
//--------------------------------------------------------------------
module loeffler_dct8 (
    input  logic                            clock,
    input  logic                            nreset,
    output logic [dct_fixed_pkg::IDX_W-1:0] fetch_addr,
    input  dct_fixed_pkg::sample_t          src_data,
    output logic                            result_wren,
    output logic [dct_fixed_pkg::IDX_W-1:0] result_addr,
    output dct_fixed_pkg::sample_t          result_data,
    output logic                            finished
);
    import dct_fixed_pkg::*;
    import dct_ucode_pkg::*;

    ucode_t  ctrl;
    sample_t operand_bus;
    sample_t mul_product;
    sample_t spad_rdata;
    sample_t spad_wdata;
    logic    spad_wren;

    assign fetch_addr = ctrl.read_addr[IDX_W-1:0];

    dct_sequencer seq0 (
        .clock    (clock),
        .nreset   (nreset),
        .ctrl     (ctrl),
        .finished (finished)
    );

    dct_datapath dp0 (
        .clock       (clock),
        .nreset      (nreset),
        .ctrl        (ctrl),
        .src_data    (src_data),
        .spad_data   (spad_rdata),
        .mul_product (mul_product),
        .operand_bus (operand_bus),
        .spad_wren   (spad_wren),
        .spad_wdata  (spad_wdata),
        .result_wren (result_wren),
        .result_addr (result_addr),
        .result_data (result_data)
    );

    dct_multiplier mul0 (
        .clock     (clock),
        .nreset    (nreset),
        .operand   (operand_bus),
        .coeff_sel (ctrl.coeff_sel),
        .product   (mul_product)
    );

    dct_scratchpad spad0 (
        .clock      (clock),
        .read_addr  (ctrl.read_addr),
        .read_data  (spad_rdata),
        .write_en   (spad_wren),
        .write_addr (ctrl.write_addr),
        .write_data (spad_wdata)
    );

endmodule

/* tests/tb_dct_model.svh */
//----------------------------------------------------------------------
// reference model of the 8-point DCT dataflow and the compare tasks
// included inside the testbench module after the package imports
//----------------------------------------------------------------------
`ifndef TB_DCT_MODEL_SVH
`define TB_DCT_MODEL_SVH

typedef sample_t [POINTS-1:0] block_t;     // eight samples, element i is point i

typedef struct packed {
    block_t x;   // input samples
    block_t y;   // expected results
} test_vec_t;

// 7Q8 times a 1Q8 constant, kept to the 7Q8 slice
function automatic sample_t mul_q(sample_t a, coeff_t c);
    int p;
    p = int'(a) * int'({1'b0, c});
    return p[23:8];
endfunction

function automatic block_t dct_model(block_t x);
    sample_t s[POINTS];
    sample_t e[4];
    sample_t f[4];
    sample_t a;
    sample_t b;
    sample_t c;
    sample_t d;
    block_t  y;
    for (int i = 0; i < 4; i++) begin
        s[i]     = x[i] + x[7-i];   // all sums wrap to 16 bits
        s[7-i]   = x[i] - x[7-i];
    end
    e[0] = s[0] + s[3];
    e[1] = s[1] + s[2];
    e[2] = s[1] - s[2];
    e[3] = s[0] - s[3];
    a = mul_q(s[4], C3_COS) + mul_q(s[7], C3_SIN);
    d = mul_q(s[7], C3_COS) - mul_q(s[4], C3_SIN);
    b = mul_q(s[5], C1_COS) + mul_q(s[6], C1_SIN);
    c = mul_q(s[6], C1_COS) - mul_q(s[5], C1_SIN);
    y[0] = mul_q(e[0], SQRT2_Q) + mul_q(e[1], SQRT2_Q);
    y[4] = mul_q(e[0], SQRT2_Q) - mul_q(e[1], SQRT2_Q);
    y[2] = mul_q(e[2], R2C6_COS) + mul_q(e[3], R2C6_SIN);
    y[6] = mul_q(e[3], R2C6_COS) - mul_q(e[2], R2C6_SIN);
    f[0] = a + c;
    f[1] = d - b;
    f[2] = a - c;
    f[3] = b + d;
    y[1] = f[0] + f[3];
    y[7] = f[3] - f[0];
    y[3] = mul_q(f[1], SQRT2);
    y[5] = mul_q(f[2], SQRT2);
    return y;
endfunction

task automatic check_result(string name, int idx, sample_t exp, sample_t act);
    if (act !== exp) begin
        $display("[ERROR] %s result %0d: expected %0d, actual %0d", name, idx, exp, act);
        stop_on_error();
    end
endtask

task automatic check_mask(string name, logic [POINTS-1:0] exp, logic [POINTS-1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s strobe mask: expected %b, actual %b", name, exp, act);
        stop_on_error();
    end
endtask

`endif

/* tests/tb_loeffler_dct8.sv */
`timescale 1ns/1ns
//----------------------------------------------------------------------
// testbench for the 8-point Loeffler DCT engine
// models the input buffer, runs a vector table and random vectors
// through the DUT and checks every result against the model
//----------------------------------------------------------------------
module tb_loeffler_dct8;
    import dct_fixed_pkg::*;
    import dct_ucode_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_TABLE    = 6;
    localparam int N_RANDOM   = 20;
    localparam int N_RUNS     = N_TABLE + N_RANDOM + 2;   // plus interrupted run and its rerun
    localparam int RUN_CYCLES = UCODE_LEN + 10;

    logic             clock;
    logic             nreset;
    logic [IDX_W-1:0] fetch_addr;
    sample_t          src_data;
    logic             result_wren;
    logic [IDX_W-1:0] result_addr;
    sample_t          result_data;
    logic             finished;

    sample_t          buffer [POINTS];
    sample_t          captured [POINTS];
    logic [POINTS-1:0] written;
    integer           seed = 32'h1ad683b5;

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    `include "tb_dct_model.svh"

    test_vec_t vectors [N_TABLE];
    string     vec_names [N_TABLE];

    loeffler_dct8 dut0 (
        .clock       (clock),
        .nreset      (nreset),
        .fetch_addr  (fetch_addr),
        .src_data    (src_data),
        .result_wren (result_wren),
        .result_addr (result_addr),
        .result_data (result_data),
        .finished    (finished)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // input buffer with one clock of read latency
    always @(posedge clock) begin
        src_data <= buffer[fetch_addr];
    end

    // result strobes are sampled half a clock after the edge
    always @(negedge clock) begin
        if (!nreset && result_wren) begin
            if (finished) begin
                $display("result strobe for index %0d after finished rose", result_addr);
                stop_on_error();
            end
            if (written[result_addr]) begin
                $display("result index %0d written more than once", result_addr);
                stop_on_error();
            end
            captured[result_addr] = result_data;
            written[result_addr]  = 1'b1;
        end
    end

    function automatic void build_vectors();
        for (int n = 0; n < N_TABLE; n++) begin
            vectors[n] = '0;
        end
        vec_names[0] = "all zero";          // expected stays zero
        vec_names[1] = "constant";
        for (int i = 0; i < POINTS; i++) begin
            vectors[1].x[i] = 16'sh0100;
        end
        vectors[1].y[0] = 16'sd728;         // 2 * (1024 * 91 >> 8) and zero elsewhere
        vec_names[2] = "impulse";
        vectors[2].x[0] = 16'sh0100;
        vec_names[3] = "alternating";
        vec_names[4] = "extremes high";
        vec_names[5] = "extremes mixed";
        for (int i = 0; i < POINTS; i++) begin
            vectors[3].x[i] = (i % 2 == 0) ? 16'sh0200 : -16'sh0200;
            vectors[4].x[i] = 16'sh7fff;
            vectors[5].x[i] = (i % 2 == 0) ? 16'sh7fff : 16'sh8000;
        end
        for (int n = 2; n < N_TABLE; n++) begin
            vectors[n].y = dct_model(vectors[n].x);
        end
    endfunction

    // reset held for two rising edges while the buffer is loaded
    task automatic reset_and_load(string name, block_t x);
        @(posedge clock);
        nreset <= 1'b1;
        for (int i = 0; i < POINTS; i++) begin
            buffer[i] <= x[i];
        end
        written = '0;
        @(posedge clock);
        @(negedge clock);
        if (result_wren !== 1'b0 || finished !== 1'b0) begin
            $display("%s: result_wren or finished high during reset", name);
            stop_on_error();
        end
        @(posedge clock);
        nreset <= 1'b0;
        @(negedge clock);
        if (result_wren !== 1'b0 || finished !== 1'b0) begin
            $display("%s: result_wren or finished high at the end of reset", name);
            stop_on_error();
        end
    endtask

    task automatic wait_finished(string name);
        int cycles;
        cycles = 0;
        while (finished !== 1'b1 && cycles <= RUN_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (finished !== 1'b1) begin
            $display("%s: finished did not rise within %0d cycles", name, cycles);
            stop_on_error();
        end
    endtask

    task automatic run_vector(string name, test_vec_t t);
        reset_and_load(name, t.x);
        wait_finished(name);
        check_mask(name, {POINTS{1'b1}}, written);
        repeat (3) @(negedge clock);   // any late strobe is caught by the monitor
        for (int i = 0; i < POINTS; i++) begin
            check_result(name, i, t.y[i], captured[i]);
        end
    endtask

    initial begin
        #(N_RUNS * RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all vectors completed");
        stop_on_error();
    end

    initial begin
        test_vec_t t;
        clock    = 1'b0;
        nreset   = 1'b1;
        src_data = '0;
        written  = '0;
        for (int i = 0; i < POINTS; i++) begin
            buffer[i] = '0;
        end
        build_vectors();

        for (int n = 0; n < N_TABLE; n++) begin
            run_vector(vec_names[n], vectors[n]);
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            for (int i = 0; i < POINTS; i++) begin
                t.x[i] = sample_t'($random(seed));
            end
            t.y = dct_model(t.x);
            run_vector($sformatf("random %0d", n), t);
        end

        // stop a transform halfway after some results went out
        for (int i = 0; i < POINTS; i++) begin
            t.x[i] = sample_t'($random(seed));
        end
        reset_and_load("interrupted", t.x);
        repeat (35) @(negedge clock);
        if (finished !== 1'b0) begin
            $display("interrupted: finished high in the middle of the program");
            stop_on_error();
        end
        run_vector("after restart", vectors[3]);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* loeffler_dct8.f */
+incdir+tests
logic/dct_fixed_pkg.sv
logic/dct_ucode_pkg.sv
logic/dct_scratchpad.sv
logic/dct_multiplier.sv
logic/dct_sequencer.sv
logic/dct_datapath.sv
logic/loeffler_dct8.sv
tests/tb_loeffler_dct8.sv

/* Bender.yml */
package:
  name: loeffler_dct8

dependencies: {}

sources:
  # packages first, then the RTL bottom up
  - files:
      - logic/dct_fixed_pkg.sv
      - logic/dct_ucode_pkg.sv
      - logic/dct_scratchpad.sv
      - logic/dct_multiplier.sv
      - logic/dct_sequencer.sv
      - logic/dct_datapath.sv
      - logic/loeffler_dct8.sv

  # testbench, top module tb_loeffler_dct8
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_loeffler_dct8.sv
